// ==== uart_peripheral.f ====
source/arch_defs_pkg.sv
source/uart_line_pkg.sv
source/uart_transmitter.sv
source/uart_receiver.sv
source/uart_peripheral.sv
verif/uart_peripheral_sva.sv
verif/tb_uart_peripheral.sv

// ==== Makefile ====
# Verilator flow for the UART peripheral

VERILATOR  ?= verilator
TB_TOP     ?= tb_uart_peripheral
RTL_TOP    ?= uart_peripheral
FILELIST   ?= uart_peripheral.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_uart_peripheral.sv ====
`timescale 1ns/1ps

module tb_uart_peripheral
    import arch_defs_pkg::*;
    import uart_line_pkg::*;
();

    localparam int CLKS_PER_BIT = 8;
    // Upper bound on any wait in clock cycles
    localparam int WAIT_CYCLES  = 4 * FRAME_BITS * CLKS_PER_BIT;

    logic                  clk = 1'b0;
    logic                  reset;
    uart_reg_offset_e      address_offset;
    logic                  cmd_enable;
    logic                  cmd_write;
    logic                  cmd_read;
    logic [DATA_WIDTH-1:0] parallel_data_in;
    logic [DATA_WIDTH-1:0] parallel_data_out;
    logic                  serial_rx;
    logic                  serial_tx;

    int     error_count;
    int     check_count;
    integer seed;

    always #5 clk = ~clk;

    uart_peripheral #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_peripheral_i (
        .clk             (clk),
        .reset           (reset),
        .address_offset_i(address_offset),
        .cmd_enable_i    (cmd_enable),
        .cmd_write_i     (cmd_write),
        .cmd_read_i      (cmd_read),
        .parallel_data_i (parallel_data_in),
        .parallel_data_o (parallel_data_out),
        .serial_rx_i     (serial_rx),
        .serial_tx_o     (serial_tx)
    );

    // ==================================================
    // Checks and bus access
    // ==================================================
    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("[FAIL] %s: got 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("[FAIL] %s: got 0x%01h, expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic reg_write(input uart_reg_offset_e offset, input logic [7:0] data);
        @(posedge clk);
        address_offset   <= offset;
        cmd_enable       <= 1'b1;
        cmd_write        <= 1'b1;
        parallel_data_in <= data;
        @(posedge clk);
        cmd_enable <= 1'b0;
        cmd_write  <= 1'b0;
    endtask

    // Read data is combinational, so sample it mid-cycle
    task automatic reg_read(input uart_reg_offset_e offset, output logic [7:0] data);
        @(posedge clk);
        address_offset <= offset;
        cmd_enable     <= 1'b1;
        cmd_read       <= 1'b1;
        @(negedge clk);
        data = parallel_data_out;
        @(posedge clk);
        cmd_enable <= 1'b0;
        cmd_read   <= 1'b0;
    endtask

    task automatic wait_status_bit(input int bit_pos, input logic value, input string what);
        logic [7:0] status;
        int         cycles;
        cycles = 0;
        reg_read(UART_REG_STATUS, status);
        while (status[bit_pos] !== value && cycles < WAIT_CYCLES) begin
            reg_read(UART_REG_STATUS, status);
            cycles += 2;
        end
        check_count++;
        assert (status[bit_pos] === value) else begin
            error_count++;
            $display("Timed out waiting for %s", what);
        end
    endtask

    // ==================================================
    // Serial line model
    // ==================================================
    task automatic drive_line_bit(input logic value);
        @(posedge clk);
        serial_rx <= value;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic send_serial_byte(input logic [7:0] data, input logic stop_bit);
        drive_line_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_line_bit(data[i]);
        end
        drive_line_bit(stop_bit);
        // One idle bit so the next start edge is clean
        drive_line_bit(1'b1);
    endtask

    task automatic capture_serial_byte(output logic [7:0] data);
        int cycles;
        cycles = 0;
        data   = '0;
        @(negedge clk);
        while (serial_tx !== 1'b0 && cycles < WAIT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        check_count++;
        assert (serial_tx === 1'b0) else begin
            error_count++;
            $display("No start bit seen on serial_tx_o");
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        check_bit("serial_tx_o start bit", serial_tx, 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = serial_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_bit("serial_tx_o stop bit", serial_tx, 1'b1);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_reset_config();
        logic [7:0] value;
        logic [7:0] got;
        reg_read(UART_REG_STATUS, got);
        check_value("parallel_data_o status after reset", got, 8'h01);
        reg_read(UART_REG_CONFIG, got);
        check_value("parallel_data_o config after reset", got, 8'h00);
        value = 8'($random(seed));
        reg_write(UART_REG_CONFIG, value);
        reg_read(UART_REG_CONFIG, got);
        check_value("parallel_data_o config readback", got, value);
        reg_write(UART_REG_CONFIG, 8'h00);
    endtask

    task automatic test_transmit();
        logic [7:0] byte_out;
        logic [7:0] got;
        logic [7:0] status;
        byte_out = 8'($random(seed));
        reg_write(UART_REG_DATA, byte_out);
        fork
            capture_serial_byte(got);
            begin
                reg_read(UART_REG_STATUS, status);
                check_bit("parallel_data_o tx empty in frame",
                          status[STATUS_TX_BUFFER_EMPTY_BIT], 1'b0);
            end
        join
        check_value("serial_tx_o data", got, byte_out);
        wait_status_bit(STATUS_TX_BUFFER_EMPTY_BIT, 1'b1, "transmitter empty");
    endtask

    task automatic test_receive();
        logic [7:0] byte_in;
        logic [7:0] got;
        byte_in = 8'($random(seed));
        send_serial_byte(byte_in, 1'b1);
        wait_status_bit(STATUS_RX_DATA_READY_BIT, 1'b1, "receive data ready");
        reg_read(UART_REG_DATA, got);
        check_value("parallel_data_o rx data", got, byte_in);
        reg_read(UART_REG_STATUS, got);
        check_bit("parallel_data_o rx ready after read", got[STATUS_RX_DATA_READY_BIT], 1'b0);
    endtask

    task automatic test_frame_error();
        logic [7:0] byte_in;
        logic [7:0] extra_byte;
        logic [7:0] got;
        byte_in    = 8'($random(seed));
        extra_byte = 8'($random(seed));
        if (extra_byte == byte_in) begin
            extra_byte = ~byte_in;
        end
        send_serial_byte(byte_in, 1'b0);
        // Second byte lands while the first is unread and raises overrun
        send_serial_byte(extra_byte, 1'b1);
        wait_status_bit(STATUS_ERROR_FRAME_BIT, 1'b1, "frame error flag");
        wait_status_bit(STATUS_ERROR_OVERSHOOT_BIT, 1'b1, "overrun flag");
        // Byte is kept even with a bad stop bit
        reg_read(UART_REG_DATA, got);
        check_value("parallel_data_o rx data", got, byte_in);
        reg_write(UART_REG_COMMAND, 8'(1 << CMD_CLEAR_FRAME_ERR_BIT));
        reg_read(UART_REG_STATUS, got);
        check_bit("parallel_data_o frame error", got[STATUS_ERROR_FRAME_BIT], 1'b0);
        check_bit("parallel_data_o overrun", got[STATUS_ERROR_OVERSHOOT_BIT], 1'b1);
        reg_write(UART_REG_COMMAND, 8'(1 << CMD_CLEAR_OVERSHOOT_ERR_BIT));
    endtask

    task automatic test_overrun();
        logic [7:0] first_byte;
        logic [7:0] second_byte;
        logic [7:0] got;
        first_byte  = 8'($random(seed));
        second_byte = 8'($random(seed));
        if (second_byte == first_byte) begin
            second_byte = ~first_byte;
        end
        send_serial_byte(first_byte, 1'b1);
        send_serial_byte(second_byte, 1'b1);
        wait_status_bit(STATUS_ERROR_OVERSHOOT_BIT, 1'b1, "overrun flag");
        reg_read(UART_REG_DATA, got);
        check_value("parallel_data_o first byte", got, first_byte);
        reg_write(UART_REG_COMMAND, 8'(1 << CMD_CLEAR_OVERSHOOT_ERR_BIT));
        reg_read(UART_REG_STATUS, got);
        check_bit("parallel_data_o overrun", got[STATUS_ERROR_OVERSHOOT_BIT], 1'b0);
        check_bit("parallel_data_o rx ready", got[STATUS_RX_DATA_READY_BIT], 1'b0);
    endtask

    task automatic test_loopback();
        logic [7:0] byte_out;
        logic [7:0] got;
        logic       done;
        logic       line_ok;
        byte_out = 8'($random(seed));
        done     = 1'b0;
        line_ok  = 1'b1;
        reg_write(UART_REG_CONFIG, 8'(1 << CONFIG_LOOPBACK_BIT));
        fork
            begin
                reg_write(UART_REG_DATA, byte_out);
                wait_status_bit(STATUS_RX_DATA_READY_BIT, 1'b1, "loopback data ready");
                done = 1'b1;
            end
            while (!done && line_ok) begin
                @(negedge clk);
                check_count++;
                assert (serial_tx === 1'b1) else begin
                    error_count++;
                    line_ok = 1'b0;
                    $display("[FAIL] serial_tx_o: got 0x%01h, expected 0x1", serial_tx);
                end
            end
        join
        reg_read(UART_REG_DATA, got);
        check_value("parallel_data_o loopback data", got, byte_out);
        wait_status_bit(STATUS_TX_BUFFER_EMPTY_BIT, 1'b1, "transmitter empty");
        reg_write(UART_REG_CONFIG, 8'h00);
    endtask

    initial begin
        seed             = 32'h0a77_0235;
        error_count      = 0;
        check_count      = 0;
        reset            = 1'b1;
        address_offset   = UART_REG_CONFIG;
        cmd_enable       = 1'b0;
        cmd_write        = 1'b0;
        cmd_read         = 1'b0;
        parallel_data_in = '0;
        serial_rx        = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        test_reset_config();
        test_transmit();
        test_receive();
        test_frame_error();
        test_overrun();
        test_loopback();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verif/uart_peripheral_sva.sv ====
`timescale 1ns/1ps

module uart_peripheral_sva
    import arch_defs_pkg::*;
(
    input logic                  clk,
    input logic                  reset,
    input uart_reg_offset_e      address_offset_i,
    input logic                  cmd_enable_i,
    input logic                  cmd_write_i,
    input logic [DATA_WIDTH-1:0] parallel_data_i,
    input logic                  serial_tx_i,
    input logic                  tx_busy_i,
    input logic                  loopback_en_i,
    input logic                  rx_data_ready_i,
    input logic                  read_ack_i,
    input logic                  frame_error_flag_i,
    input logic                  overrun_error_flag_i
);

    logic command_write;

    assign command_write = cmd_enable_i && cmd_write_i
                           && (address_offset_i == UART_REG_COMMAND);

    // Pin sits high until a frame opens with a low start bit
    tx_idle_high: assert property (@(posedge clk) disable iff (reset)
        $rose(tx_busy_i) |-> $past(serial_tx_i) && (loopback_en_i || !serial_tx_i))
        else $error("serial_tx_o wrong at the start of a frame");

    rx_ready_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(rx_data_ready_i) |-> $past(read_ack_i))
        else $error("rx data ready fell without a read acknowledge");

    // Sticky flags leave only through the command register
    frame_flag_clear: assert property (@(posedge clk) disable iff (reset)
        $fell(frame_error_flag_i)
        |-> $past(command_write && parallel_data_i[CMD_CLEAR_FRAME_ERR_BIT]))
        else $error("frame error flag cleared without a command write");

    overrun_flag_clear: assert property (@(posedge clk) disable iff (reset)
        $fell(overrun_error_flag_i)
        |-> $past(command_write && parallel_data_i[CMD_CLEAR_OVERSHOOT_ERR_BIT]))
        else $error("overrun flag cleared without a command write");

endmodule

bind uart_peripheral uart_peripheral_sva uart_peripheral_sva_i (
    .clk                 (clk),
    .reset               (reset),
    .address_offset_i    (address_offset_i),
    .cmd_enable_i        (cmd_enable_i),
    .cmd_write_i         (cmd_write_i),
    .parallel_data_i     (parallel_data_i),
    .serial_tx_i         (serial_tx_o),
    .tx_busy_i           (tx_busy),
    .loopback_en_i       (loopback_en),
    .rx_data_ready_i     (rx_data_ready),
    .read_ack_i          (read_ack),
    .frame_error_flag_i  (frame_error_flag),
    .overrun_error_flag_i(overrun_error_flag)
);

// ==== source/uart_peripheral.sv ====
`timescale 1ns/1ps

module uart_peripheral
    import arch_defs_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                  clk,
    input  logic                  reset,

    // CPU register port
    input  uart_reg_offset_e      address_offset_i,
    input  logic                  cmd_enable_i,
    input  logic                  cmd_write_i,
    input  logic                  cmd_read_i,
    input  logic [DATA_WIDTH-1:0] parallel_data_i,
    output logic [DATA_WIDTH-1:0] parallel_data_o,

    // Serial line
    input  logic                  serial_rx_i,
    output logic                  serial_tx_o
);

    // ==================================================
    // Internal signals
    // ==================================================
    logic [DATA_WIDTH-1:0] config_reg;
    logic [DATA_WIDTH-1:0] config_next;
    logic                  loopback_en;

    // One-cycle command strobes from the decoder
    logic                  tx_start;
    logic                  clear_frame_err;
    logic                  clear_overrun_err;

    logic                  tx_busy;
    logic                  tx_serial;
    logic                  rx_line;
    logic                  rx_data_ready;
    logic [DATA_WIDTH-1:0] rx_data;
    logic                  frame_error_pulse;
    logic                  overrun_pulse;

    logic                  frame_error_flag;
    logic                  overrun_error_flag;
    logic [3:0]            status_word;

    logic                  data_read;
    logic                  data_read_d;
    logic                  read_ack;

    assign loopback_en = config_reg[CONFIG_LOOPBACK_BIT];

    assign status_word[STATUS_TX_BUFFER_EMPTY_BIT] = !tx_busy;
    assign status_word[STATUS_RX_DATA_READY_BIT]   = rx_data_ready;
    assign status_word[STATUS_ERROR_FRAME_BIT]     = frame_error_flag;
    assign status_word[STATUS_ERROR_OVERSHOOT_BIT] = overrun_error_flag;

    // ==================================================
    // Register decode
    // ==================================================
    always_comb begin
        config_next       = config_reg;
        parallel_data_o   = '0;
        tx_start          = 1'b0;
        clear_frame_err   = 1'b0;
        clear_overrun_err = 1'b0;

        if (cmd_enable_i) begin
            case (address_offset_i)
                UART_REG_CONFIG: begin
                    if (cmd_write_i) begin
                        config_next = parallel_data_i;
                    end else if (cmd_read_i) begin
                        parallel_data_o = config_reg;
                    end
                end
                UART_REG_STATUS: begin
                    if (cmd_read_i) begin
                        parallel_data_o = DATA_WIDTH'(status_word);
                    end
                end
                UART_REG_DATA: begin
                    // Dropped by the transmitter when it is busy
                    if (cmd_write_i) begin
                        tx_start = 1'b1;
                    end else if (cmd_read_i) begin
                        parallel_data_o = rx_data;
                    end
                end
                UART_REG_COMMAND: begin
                    if (cmd_write_i) begin
                        clear_frame_err   = parallel_data_i[CMD_CLEAR_FRAME_ERR_BIT];
                        clear_overrun_err = parallel_data_i[CMD_CLEAR_OVERSHOOT_ERR_BIT];
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            config_reg <= '0;
        end else begin
            config_reg <= config_next;
        end
    end

    // Sticky error flags, a clear beats a set in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_error_flag   <= 1'b0;
            overrun_error_flag <= 1'b0;
        end else begin
            if (clear_frame_err) begin
                frame_error_flag <= 1'b0;
            end else if (frame_error_pulse) begin
                frame_error_flag <= 1'b1;
            end

            if (clear_overrun_err) begin
                overrun_error_flag <= 1'b0;
            end else if (overrun_pulse) begin
                overrun_error_flag <= 1'b1;
            end
        end
    end

    // ==================================================
    // Read acknowledge, once per data read burst
    // ==================================================
    assign data_read = cmd_enable_i && cmd_read_i && !cmd_write_i
                       && (address_offset_i == UART_REG_DATA);

    always_ff @(posedge clk) begin
        if (reset) begin
            data_read_d <= 1'b0;
        end else begin
            data_read_d <= data_read;
        end
    end

    assign read_ack = data_read && !data_read_d;

    // Loopback feeds the transmitter into the receiver and parks the pin
    assign rx_line     = loopback_en ? tx_serial : serial_rx_i;
    assign serial_tx_o = loopback_en ? 1'b1 : tx_serial;

    // ==================================================
    // Serial engines
    // ==================================================
    uart_receiver #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_receiver (
        .clk            (clk),
        .reset          (reset),
        .serial_rx_i    (rx_line),
        .read_ack_i     (read_ack),
        .rx_data_o      (rx_data),
        .rx_data_ready_o(rx_data_ready),
        .frame_error_o  (frame_error_pulse),
        .overrun_o      (overrun_pulse)
    );

    uart_transmitter #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_transmitter (
        .clk        (clk),
        .reset      (reset),
        .tx_data_i  (parallel_data_i),
        .tx_start_i (tx_start),
        .tx_busy_o  (tx_busy),
        .serial_tx_o(tx_serial)
    );

endmodule

// ==== source/uart_receiver.sv ====
`timescale 1ns/1ps

module uart_receiver
    import arch_defs_pkg::*;
    import uart_line_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  serial_rx_i,
    input  logic                  read_ack_i,
    output logic [DATA_WIDTH-1:0] rx_data_o,
    output logic                  rx_data_ready_o,
    output logic                  frame_error_o,
    output logic                  overrun_o
);

    localparam int CNT_W    = $clog2(CLKS_PER_BIT);
    localparam int IDX_W    = $clog2(DATA_WIDTH);
    localparam int HALF_BIT = CLKS_PER_BIT / 2;

    // ==================================================
    // Line synchronizer and start edge
    // ==================================================
    logic rx_meta;
    logic rx_sync;
    logic rx_sync_d;
    logic start_edge;

    // Idle line is high, so the flops come out of reset high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta   <= 1'b1;
            rx_sync   <= 1'b1;
            rx_sync_d <= 1'b1;
        end else begin
            rx_meta   <= serial_rx_i;
            rx_sync   <= rx_meta;
            rx_sync_d <= rx_sync;
        end
    end

    assign start_edge = rx_sync_d && !rx_sync;

    // ==================================================
    // Bit sampling FSM
    // ==================================================
    rx_state_e             state;
    logic [CNT_W-1:0]      clk_cnt;
    logic [IDX_W-1:0]      bit_idx;
    logic                  half_done;
    logic                  bit_done;
    logic                  stop_done;
    logic                  ready_held;
    logic                  store_byte;
    logic [DATA_WIDTH-1:0] rx_shift;

    assign half_done  = (clk_cnt == CNT_W'(HALF_BIT - 1));
    assign bit_done   = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign stop_done  = (state == RX_STOP) && bit_done;
    // Old byte still unread unless the CPU acknowledges it this cycle
    assign ready_held = rx_data_ready_o && !read_ack_i;
    assign store_byte = stop_done && !ready_held;

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= RX_IDLE;
            clk_cnt         <= '0;
            bit_idx         <= '0;
            rx_data_ready_o <= 1'b0;
            frame_error_o   <= 1'b0;
            overrun_o       <= 1'b0;
        end else begin
            frame_error_o <= 1'b0;
            overrun_o     <= 1'b0;

            if (store_byte) begin
                rx_data_ready_o <= 1'b1;
            end else if (read_ack_i) begin
                rx_data_ready_o <= 1'b0;
            end

            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (start_edge) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_done) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // Line back high by mid-bit means a glitch
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(DATA_WIDTH - 1)) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_done) begin
                        clk_cnt       <= '0;
                        state         <= RX_IDLE;
                        frame_error_o <= !rx_sync;
                        overrun_o     <= ready_held;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_done) begin
            rx_shift <= {rx_sync, rx_shift[DATA_WIDTH-1:1]};
        end
        if (store_byte) begin
            rx_data_o <= rx_shift;
        end
    end

endmodule

// ==== source/uart_transmitter.sv ====
`timescale 1ns/1ps

module uart_transmitter
    import arch_defs_pkg::*;
    import uart_line_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [DATA_WIDTH-1:0] tx_data_i,
    input  logic                  tx_start_i,
    output logic                  tx_busy_o,
    output logic                  serial_tx_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(DATA_WIDTH);

    tx_state_e        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [IDX_W-1:0] bit_idx;
    logic             bit_done;

    // Whole frame, start bit in position 0 and stop bit on top
    logic [FRAME_BITS-1:0] tx_shift;

    assign bit_done = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    // ==================================================
    // Frame sequencing
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            // Bit timer runs only inside a frame
            if (state == TX_IDLE || bit_done) begin
                clk_cnt <= '0;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end

            case (state)
                TX_IDLE: begin
                    if (tx_start_i) begin
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(DATA_WIDTH - 1)) begin
                            state <= TX_STOP;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        state <= TX_IDLE;
                    end
                end
            endcase
        end
    end

    // Load on an accepted start, then shift right filling with ones
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start_i) begin
            tx_shift <= {1'b1, tx_data_i, 1'b0};
        end else if (state != TX_IDLE && bit_done) begin
            tx_shift <= {1'b1, tx_shift[FRAME_BITS-1:1]};
        end
    end

    assign tx_busy_o   = (state != TX_IDLE);
    assign serial_tx_o = (state == TX_IDLE) ? 1'b1 : tx_shift[0];

endmodule

// ==== source/uart_line_pkg.sv ====
package uart_line_pkg;

    // ==================================================
    // 8N1 line format
    // ==================================================
    // Start bit, eight data bits and one stop bit
    localparam int FRAME_BITS = 10;

    // ==================================================
    // Serial engine states
    // ==================================================
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    // Receiver samples each bit at its middle
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

// ==== source/arch_defs_pkg.sv ====
package arch_defs_pkg;

    // ==================================================
    // CPU bus and character width
    // ==================================================
    localparam int DATA_WIDTH = 8;

    // ==================================================
    // Register map, word offsets on the CPU port
    // ==================================================
    typedef enum logic [1:0] {
        UART_REG_CONFIG  = 2'd0,
        UART_REG_STATUS  = 2'd1,
        UART_REG_DATA    = 2'd2,
        UART_REG_COMMAND = 2'd3
    } uart_reg_offset_e;

    // Status word bit positions
    localparam int STATUS_TX_BUFFER_EMPTY_BIT = 0;
    localparam int STATUS_RX_DATA_READY_BIT   = 1;
    localparam int STATUS_ERROR_FRAME_BIT     = 2;
    localparam int STATUS_ERROR_OVERSHOOT_BIT = 3;

    // Command word, write 1 to clear the matching sticky flag
    localparam int CMD_CLEAR_FRAME_ERR_BIT     = 0;
    localparam int CMD_CLEAR_OVERSHOOT_ERR_BIT = 1;

    // Config word
    localparam int CONFIG_LOOPBACK_BIT = 0;

endpackage
